/* Makefile */
SIM        = verilator
TB_TOP     = tb_yuv_to_rgb
RTL_TOP    = yuv_to_rgb_core
FILELIST   = list.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing -Wno-fatal
PASS_MSG   = >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* include/yuv_defs.svh */
`ifndef YUV_DEFS_SVH
`define YUV_DEFS_SVH

// Six-tap chroma interpolation
`define TAP_OUTER     21
// Middle tap is subtracted
`define TAP_MID       52
`define TAP_INNER     159
`define CHROMA_ROUND  128
`define CHROMA_SHIFT  8

// Offsets removed before the matrix
`define LUMA_OFFSET   16
`define CHROMA_OFFSET 128

// Fixed-point colour matrix, scaled by 2^16
`define COEF_Y        76284
`define COEF_RV       104595
`define COEF_GU       25624
`define COEF_GV       53281
`define COEF_BU       132251
`define RGB_SHIFT     16

// Upper clip for chroma and colour channels
`define CHANNEL_MAX   255

// Row geometry, in pixel pairs (at least 4)
`define ROW_PAIRS     160
// Pairs held back by the filter window
`define LOOKAHEAD     3

`endif

/* list.f */
+incdir+include
rtl/pixel_pkg.sv
rtl/ctrl_pkg.sv
rtl/chroma_upsampler.sv
rtl/rgb_converter.sv
rtl/yuv_to_rgb_core.sv
tb/tb_clock_gen.sv
tb/tb_yuv_to_rgb.sv

/* rtl/chroma_upsampler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "yuv_defs.svh"

module chroma_upsampler (
	input  logic               CLOCK_50_I,
	input  logic               resetn,
	input  logic               pair_strobe,
	input  pixel_pkg::sample_t chroma_in,
	output logic               out_strobe,
	output pixel_pkg::sample_t chroma_even,
	output pixel_pkg::sample_t chroma_odd
);

	import pixel_pkg::*;
	import ctrl_pkg::*;

	localparam int CNT_W = $clog2(`ROW_PAIRS + `LOOKAHEAD + 1);

	ups_state_t state;
	logic [CNT_W-1:0] pair_cnt;

	// Index 0 is the newest sample, index 5 the oldest
	sample_t win [6];
	sample_t win_next [6];
	sample_t shift_sample;
	logic shift_en;
	logic emit;

	tap_sum_t outer_sum;
	tap_sum_t mid_sum;
	tap_sum_t inner_sum;
	tap_sum_t filt_sum;
	tap_sum_t filt_shifted;
	sample_t odd_clipped;

	////////////////////////////////////////
	// Window control
	////////////////////////////////////////

	always_comb begin
		shift_en = 1'b0;
		shift_sample = chroma_in;
		case (state)
			UPS_FILL, UPS_RUN: shift_en = pair_strobe;
			UPS_FLUSH: begin
				// Last sample of the row repeats into the newer slots
				shift_en = 1'b1;
				shift_sample = win[0];
			end
			default: shift_en = 1'b0;
		endcase
		emit = (state == UPS_RUN && pair_strobe) || state == UPS_FLUSH;
	end

	always_comb begin
		for (int i = 0; i < 6; i++) begin
			win_next[i] = win[i];
		end
		if (shift_en) begin
			win_next[0] = shift_sample;
			for (int i = 1; i < 6; i++) begin
				// First sample of a row fills the older slots too
				if (state == UPS_FILL && pair_cnt == '0)
					win_next[i] = shift_sample;
				else
					win_next[i] = win[i-1];
			end
		end
	end

	////////////////////////////////////////
	// Odd chroma filter
	////////////////////////////////////////

	// Window slot 3 is pair j, slot 0 is j+3
	always_comb begin
		outer_sum = tap_sum_t'(win_next[5]) + tap_sum_t'(win_next[0]);
		mid_sum = tap_sum_t'(win_next[4]) + tap_sum_t'(win_next[1]);
		inner_sum = tap_sum_t'(win_next[3]) + tap_sum_t'(win_next[2]);
		filt_sum = tap_sum_t'(`TAP_OUTER * outer_sum - `TAP_MID * mid_sum
			+ `TAP_INNER * inner_sum + `CHROMA_ROUND);
		filt_shifted = filt_sum >>> `CHROMA_SHIFT;
		if (filt_shifted < 0)
			odd_clipped = '0;
		else if (filt_shifted > `CHANNEL_MAX)
			odd_clipped = sample_t'(`CHANNEL_MAX);
		else
			odd_clipped = filt_shifted[7:0];
	end

	////////////////////////////////////////
	// Row FSM
	////////////////////////////////////////

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			state <= UPS_FILL;
			pair_cnt <= '0;
			out_strobe <= 1'b0;
		end else begin
			out_strobe <= emit;
			case (state)
				UPS_FILL: begin
					if (pair_strobe) begin
						pair_cnt <= pair_cnt + 1'b1;
						if (pair_cnt == CNT_W'(`LOOKAHEAD - 1))
							state <= UPS_RUN;
					end
				end
				UPS_RUN: begin
					if (pair_strobe) begin
						pair_cnt <= pair_cnt + 1'b1;
						if (pair_cnt == CNT_W'(`ROW_PAIRS - 1))
							state <= UPS_FLUSH;
					end
				end
				UPS_FLUSH: begin
					// Three trailing pairs drain on consecutive cycles
					if (pair_cnt == CNT_W'(`ROW_PAIRS + `LOOKAHEAD - 1)) begin
						pair_cnt <= '0;
						state <= UPS_FILL;
					end else begin
						pair_cnt <= pair_cnt + 1'b1;
					end
				end
				default: state <= UPS_FILL;
			endcase
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		win <= win_next;
		if (emit) begin
			chroma_even <= win_next[3];
			chroma_odd <= odd_clipped;
		end
	end

endmodule

`default_nettype wire

/* rtl/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

	// Row phase of a chroma upsampler
	typedef enum logic [1:0] {
		UPS_FILL,
		UPS_RUN,
		UPS_FLUSH
	} ups_state_t;

endpackage

`default_nettype wire

/* rtl/pixel_pkg.sv */
`default_nettype none

package pixel_pkg;

	// Raw luma or chroma sample
	typedef logic [7:0] sample_t;

	// Filter accumulator, wide enough for the full six-tap sum
	typedef logic signed [19:0] tap_sum_t;

	// Matrix products and their sums
	typedef logic signed [31:0] product_t;

	// Colour channel after clipping
	typedef logic [7:0] channel_t;

endpackage

`default_nettype wire

/* rtl/rgb_converter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "yuv_defs.svh"

module rgb_converter (
	input  logic                CLOCK_50_I,
	input  logic                resetn,
	input  logic                pair_strobe,
	input  logic                chroma_strobe,
	input  pixel_pkg::sample_t  y_even,
	input  pixel_pkg::sample_t  y_odd,
	input  pixel_pkg::sample_t  u_even,
	input  pixel_pkg::sample_t  u_odd,
	input  pixel_pkg::sample_t  v_even,
	input  pixel_pkg::sample_t  v_odd,
	output logic                rgb_strobe,
	output pixel_pkg::channel_t r_even,
	output pixel_pkg::channel_t g_even,
	output pixel_pkg::channel_t b_even,
	output pixel_pkg::channel_t r_odd,
	output pixel_pkg::channel_t g_odd,
	output pixel_pkg::channel_t b_odd
);

	import pixel_pkg::*;

	// Luma waits here for the delayed chroma
	sample_t ly_even [4];
	sample_t ly_odd [4];
	logic [1:0] wr_ptr;
	logic [1:0] rd_ptr;

	// Index 0 is the even pixel, 1 the odd one
	sample_t pix_y [2];
	sample_t pix_u [2];
	sample_t pix_v [2];

	logic s1_valid;
	product_t y_term [2];
	product_t rv_term [2];
	product_t gu_term [2];
	product_t gv_term [2];
	product_t bu_term [2];

	function automatic channel_t clip_channel(input product_t sum);
		product_t shifted;
		shifted = sum >>> `RGB_SHIFT;
		if (shifted < 0)
			return '0;
		else if (shifted > `CHANNEL_MAX)
			return channel_t'(`CHANNEL_MAX);
		return shifted[7:0];
	endfunction

	////////////////////////////////////////
	// Luma queue
	////////////////////////////////////////

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (pair_strobe)
				wr_ptr <= wr_ptr + 1'b1;
			if (chroma_strobe)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (pair_strobe) begin
			ly_even[wr_ptr] <= y_even;
			ly_odd[wr_ptr] <= y_odd;
		end
	end

	assign pix_y[0] = ly_even[rd_ptr];
	assign pix_y[1] = ly_odd[rd_ptr];
	assign pix_u[0] = u_even;
	assign pix_u[1] = u_odd;
	assign pix_v[0] = v_even;
	assign pix_v[1] = v_odd;

	////////////////////////////////////////
	// Multiply and sum pipeline
	////////////////////////////////////////

	// Stage one, ten products per pair
	always_ff @(posedge CLOCK_50_I) begin
		if (chroma_strobe) begin
			for (int p = 0; p < 2; p++) begin
				y_term[p] <= `COEF_Y * (product_t'(pix_y[p]) - `LUMA_OFFSET);
				rv_term[p] <= `COEF_RV * (product_t'(pix_v[p]) - `CHROMA_OFFSET);
				gu_term[p] <= `COEF_GU * (product_t'(pix_u[p]) - `CHROMA_OFFSET);
				gv_term[p] <= `COEF_GV * (product_t'(pix_v[p]) - `CHROMA_OFFSET);
				bu_term[p] <= `COEF_BU * (product_t'(pix_u[p]) - `CHROMA_OFFSET);
			end
		end
	end

	// Stage two, channel sums and clip
	always_ff @(posedge CLOCK_50_I) begin
		if (s1_valid) begin
			r_even <= clip_channel(y_term[0] + rv_term[0]);
			g_even <= clip_channel(y_term[0] - gu_term[0] - gv_term[0]);
			b_even <= clip_channel(y_term[0] + bu_term[0]);
			r_odd <= clip_channel(y_term[1] + rv_term[1]);
			g_odd <= clip_channel(y_term[1] - gu_term[1] - gv_term[1]);
			b_odd <= clip_channel(y_term[1] + bu_term[1]);
		end
	end

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			s1_valid <= 1'b0;
			rgb_strobe <= 1'b0;
		end else begin
			s1_valid <= chroma_strobe;
			rgb_strobe <= s1_valid;
		end
	end

endmodule

`default_nettype wire

/* rtl/yuv_to_rgb_core.sv */
`timescale 1ns/1ps
`default_nettype none

module yuv_to_rgb_core (
	input  logic                CLOCK_50_I,
	input  logic                resetn,
	input  logic                pair_strobe,
	input  pixel_pkg::sample_t  y_even,
	input  pixel_pkg::sample_t  y_odd,
	input  pixel_pkg::sample_t  u_in,
	input  pixel_pkg::sample_t  v_in,
	output logic                rgb_strobe,
	output pixel_pkg::channel_t r_even,
	output pixel_pkg::channel_t g_even,
	output pixel_pkg::channel_t b_even,
	output pixel_pkg::channel_t r_odd,
	output pixel_pkg::channel_t g_odd,
	output pixel_pkg::channel_t b_odd
);

	import pixel_pkg::*;

	logic chroma_strobe;
	sample_t u_even;
	sample_t u_odd;
	sample_t v_even;
	sample_t v_odd;

	chroma_upsampler u_upsampler (
		.CLOCK_50_I  (CLOCK_50_I),
		.resetn      (resetn),
		.pair_strobe (pair_strobe),
		.chroma_in   (u_in),
		.out_strobe  (chroma_strobe),
		.chroma_even (u_even),
		.chroma_odd  (u_odd)
	);

	// Same strobes as the U side, so its strobe is not needed
	chroma_upsampler v_upsampler (
		.CLOCK_50_I  (CLOCK_50_I),
		.resetn      (resetn),
		.pair_strobe (pair_strobe),
		.chroma_in   (v_in),
		.out_strobe  (),
		.chroma_even (v_even),
		.chroma_odd  (v_odd)
	);

	rgb_converter converter (
		.CLOCK_50_I    (CLOCK_50_I),
		.resetn        (resetn),
		.pair_strobe   (pair_strobe),
		.chroma_strobe (chroma_strobe),
		.y_even        (y_even),
		.y_odd         (y_odd),
		.u_even        (u_even),
		.u_odd         (u_odd),
		.v_even        (v_even),
		.v_odd         (v_odd),
		.rgb_strobe    (rgb_strobe),
		.r_even        (r_even),
		.g_even        (g_even),
		.b_even        (b_even),
		.r_odd         (r_odd),
		.g_odd         (g_odd),
		.b_odd         (b_odd)
	);

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic CLOCK_50_I,
	output logic resetn
);

	// 100 ns period
	initial begin
		CLOCK_50_I = 1'b0;
		forever #50 CLOCK_50_I = ~CLOCK_50_I;
	end

	// Held low for two rising edges
	initial begin
		resetn = 1'b0;
		repeat (2) @(posedge CLOCK_50_I);
		resetn <= 1'b1;
	end

endmodule

`default_nettype wire

/* tb/tb_yuv_to_rgb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "yuv_defs.svh"

module tb_yuv_to_rgb;

	import pixel_pkg::*;

	localparam int N_ROWS = 6;
	localparam int RESET_LIMIT = 10;
	localparam int DRAIN_LIMIT = 64;
	localparam int KIND_GREY = 0;
	localparam int KIND_EXTREME = 1;
	localparam int KIND_RAMP = 2;
	localparam int KIND_STEP = 3;
	localparam int KIND_RANDOM = 4;

	////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////

	int row_kind [N_ROWS] = '{KIND_GREY, KIND_EXTREME, KIND_RAMP, KIND_STEP,
		KIND_RANDOM, KIND_RANDOM};
	// Idle cycles after each row
	int row_gap [N_ROWS] = '{4, 6, 4, 9, 5, 4};
	// Random idle cycles between pairs
	bit row_jitter [N_ROWS] = '{0, 0, 1, 0, 1, 0};

	logic CLOCK_50_I;
	logic resetn;
	logic pair_strobe;
	sample_t y_even;
	sample_t y_odd;
	sample_t u_in;
	sample_t v_in;
	logic rgb_strobe;
	channel_t r_even;
	channel_t g_even;
	channel_t b_even;
	channel_t r_odd;
	channel_t g_odd;
	channel_t b_odd;

	integer seed = 32'hdd4cf105;
	sample_t row_y_even [`ROW_PAIRS];
	sample_t row_y_odd [`ROW_PAIRS];
	sample_t row_u [`ROW_PAIRS];
	sample_t row_v [`ROW_PAIRS];

	// Expected pairs in output order
	logic [47:0] exp_q [$];
	int exp_row_q [$];
	int exp_pair_q [$];
	int row_out_count [N_ROWS];
	int pairs_accepted = 0;

	int value_errors = 0;
	int count_errors = 0;
	int protocol_errors = 0;
	int timeouts = 0;
	bit reset_ok;
	bit drain_ok;
	logic [47:0] mon_exp;
	int mon_row;
	int mon_pair;

	tb_clock_gen clock_gen (
		.CLOCK_50_I (CLOCK_50_I),
		.resetn     (resetn)
	);

	yuv_to_rgb_core DUT (
		.CLOCK_50_I  (CLOCK_50_I),
		.resetn      (resetn),
		.pair_strobe (pair_strobe),
		.y_even      (y_even),
		.y_odd       (y_odd),
		.u_in        (u_in),
		.v_in        (v_in),
		.rgb_strobe  (rgb_strobe),
		.r_even      (r_even),
		.g_even      (g_even),
		.b_even      (b_even),
		.r_odd       (r_odd),
		.g_odd       (g_odd),
		.b_odd       (b_odd)
	);

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic int limit_channel(input int value);
		if (value < 0)
			return 0;
		if (value > `CHANNEL_MAX)
			return `CHANNEL_MAX;
		return value;
	endfunction

	// Row edges repeat the first and last sample
	function automatic int chroma_at(input int plane, input int idx);
		int k;
		k = (idx < 0) ? 0 : ((idx > `ROW_PAIRS - 1) ? `ROW_PAIRS - 1 : idx);
		return (plane == 0) ? int'(row_u[k]) : int'(row_v[k]);
	endfunction

	function automatic int interp_odd(input int plane, input int j);
		int acc;
		acc = `TAP_OUTER * (chroma_at(plane, j - 2) + chroma_at(plane, j + 3))
			- `TAP_MID * (chroma_at(plane, j - 1) + chroma_at(plane, j + 2))
			+ `TAP_INNER * (chroma_at(plane, j) + chroma_at(plane, j + 1))
			+ `CHROMA_ROUND;
		return limit_channel(acc >>> `CHROMA_SHIFT);
	endfunction

	function automatic logic [23:0] pixel_rgb(input int y, input int u, input int v);
		int luma;
		int r;
		int g;
		int b;
		luma = `COEF_Y * (y - `LUMA_OFFSET);
		r = (luma + `COEF_RV * (v - `CHROMA_OFFSET)) >>> `RGB_SHIFT;
		g = (luma - `COEF_GU * (u - `CHROMA_OFFSET) - `COEF_GV * (v - `CHROMA_OFFSET))
			>>> `RGB_SHIFT;
		b = (luma + `COEF_BU * (u - `CHROMA_OFFSET)) >>> `RGB_SHIFT;
		return {8'(limit_channel(r)), 8'(limit_channel(g)), 8'(limit_channel(b))};
	endfunction

	task automatic build_row(input int row);
		int k;
		for (k = 0; k < `ROW_PAIRS; k++) begin
			case (row_kind[row])
				KIND_GREY: begin
					row_y_even[k] = 8'd128;
					row_y_odd[k] = 8'd128;
					row_u[k] = 8'd128;
					row_v[k] = 8'd128;
				end
				KIND_EXTREME: begin
					row_y_even[k] = 8'd255;
					row_y_odd[k] = 8'd0;
					row_u[k] = ((k / 4) % 2 == 1) ? 8'd255 : 8'd0;
					row_v[k] = ((k / 4) % 2 == 1) ? 8'd0 : 8'd255;
				end
				KIND_RAMP: begin
					row_y_even[k] = sample_t'(k);
					row_y_odd[k] = sample_t'(k + 96);
					row_u[k] = sample_t'(k);
					row_v[k] = sample_t'(255 - k);
				end
				KIND_STEP: begin
					row_y_even[k] = 8'd100;
					row_y_odd[k] = 8'd100;
					row_u[k] = (k < `ROW_PAIRS / 2) ? 8'd16 : 8'd240;
					row_v[k] = (k < `ROW_PAIRS / 2) ? 8'd240 : 8'd16;
				end
				default: begin
					row_y_even[k] = sample_t'($random(seed));
					row_y_odd[k] = sample_t'($random(seed));
					row_u[k] = sample_t'($random(seed));
					row_v[k] = sample_t'($random(seed));
				end
			endcase
		end
		for (k = 0; k < `ROW_PAIRS; k++) begin
			exp_q.push_back({pixel_rgb(row_y_even[k], row_u[k], row_v[k]),
				pixel_rgb(row_y_odd[k], interp_odd(0, k), interp_odd(1, k))});
			exp_row_q.push_back(row);
			exp_pair_q.push_back(k);
		end
	endtask

	////////////////////////////////////////
	// Driver and waits
	////////////////////////////////////////

	task automatic drive_row(input bit jitter, input int gap);
		int k;
		int idle;
		for (k = 0; k < `ROW_PAIRS; k++) begin
			idle = jitter ? int'($unsigned($random(seed)) % 3) : 0;
			repeat (idle) begin
				@(posedge CLOCK_50_I);
				pair_strobe <= 1'b0;
			end
			@(posedge CLOCK_50_I);
			pair_strobe <= 1'b1;
			y_even <= row_y_even[k];
			y_odd <= row_y_odd[k];
			u_in <= row_u[k];
			v_in <= row_v[k];
		end
		repeat (gap) begin
			@(posedge CLOCK_50_I);
			pair_strobe <= 1'b0;
		end
	endtask

	task automatic wait_reset(output bit ok);
		int n;
		n = 0;
		while (resetn !== 1'b1 && n < RESET_LIMIT) begin
			@(posedge CLOCK_50_I);
			n++;
		end
		ok = (resetn === 1'b1);
	endtask

	task automatic wait_drain(output bit ok);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
			@(posedge CLOCK_50_I);
			n++;
		end
		ok = (exp_q.size() == 0);
		// Quiet window to catch stray strobes
		repeat (8) @(posedge CLOCK_50_I);
	endtask

	////////////////////////////////////////
	// Checks and monitor
	////////////////////////////////////////

	task automatic compare_rgb(input string name, input channel_t got, input channel_t exp,
		input int row, input int pair);
		if (got !== exp) begin
			value_errors++;
			$display("** Error at %0t: row %0d pair %0d %s = %0d, expected %0d",
				$time, row, pair, name, got, exp);
		end
	endtask

	task automatic compare_count(input int row, input int got, input int exp);
		if (got != exp) begin
			count_errors++;
			$display("** Error at %0t: row %0d gave %0d output pairs, expected %0d",
				$time, row, got, exp);
		end
	endtask

	// Pairs taken in by the DUT on its sampling edge
	always @(posedge CLOCK_50_I) begin
		if (pair_strobe === 1'b1)
			pairs_accepted++;
	end

	always @(negedge CLOCK_50_I) begin
		if (rgb_strobe === 1'b1) begin
			if (pairs_accepted < 4) begin
				protocol_errors++;
				$display("rgb_strobe went high before the first row delivered four pairs");
			end
			if (exp_q.size() == 0) begin
				protocol_errors++;
				$display("rgb_strobe went high at %0t with no pair pending", $time);
			end else begin
				mon_exp = exp_q.pop_front();
				mon_row = exp_row_q.pop_front();
				mon_pair = exp_pair_q.pop_front();
				row_out_count[mon_row]++;
				compare_rgb("r_even", r_even, mon_exp[47:40], mon_row, mon_pair);
				compare_rgb("g_even", g_even, mon_exp[39:32], mon_row, mon_pair);
				compare_rgb("b_even", b_even, mon_exp[31:24], mon_row, mon_pair);
				compare_rgb("r_odd", r_odd, mon_exp[23:16], mon_row, mon_pair);
				compare_rgb("g_odd", g_odd, mon_exp[15:8], mon_row, mon_pair);
				compare_rgb("b_odd", b_odd, mon_exp[7:0], mon_row, mon_pair);
			end
		end
	end

	initial begin
		pair_strobe = 1'b0;
		y_even = '0;
		y_odd = '0;
		u_in = '0;
		v_in = '0;
		for (int i = 0; i < N_ROWS; i++)
			row_out_count[i] = 0;
		wait_reset(reset_ok);
		if (!reset_ok) begin
			timeouts++;
			$display("Timeout: reset was not released within %0d cycles", RESET_LIMIT);
		end else begin
			for (int r = 0; r < N_ROWS; r++) begin
				build_row(r);
				drive_row(row_jitter[r], row_gap[r]);
			end
			wait_drain(drain_ok);
			if (!drain_ok) begin
				timeouts++;
				$display("Timeout: %0d expected pairs never appeared on rgb_strobe",
					exp_q.size());
			end
			for (int r = 0; r < N_ROWS; r++)
				compare_count(r, row_out_count[r], `ROW_PAIRS);
		end
		$display("Errors: %0d value, %0d count, %0d protocol, %0d timeout",
			value_errors, count_errors, protocol_errors, timeouts);
		if (value_errors + count_errors + protocol_errors + timeouts == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire
